// ==== verilog/regCore_params.svh ====
`ifndef REGCORE_PARAMS_SVH
`define REGCORE_PARAMS_SVH

// core sizing for the stack-machine register side

// data path
`define REG_DATA_W 16                 // one register word

// register file
`define REG_IDX_W  4                  // register select bits
`define REG_COUNT  16                 // entries, 2**REG_IDX_W

// instruction word
`define INSTR_W    16                 // opcode, idxA, idxB/imm
`define IMM_W      8                  // low byte, zero-extended on use

// field positions inside the instruction word
// opcode sits above idxA, idxA above idxB
// the immediate overlaps idxB and the low nibble below it
// so ADDI/LDI cannot name a second register

`endif

// ==== verilog/regCorePkg.sv ====
`include "regCore_params.svh"

package regCorePkg;

	// one-hot phase strobes, fetch is the msb
	typedef struct packed {
		logic fetch;                          // instr latched at end of this cycle
		logic decode;                         // dec valid
		logic execute;                        // port enables high
		logic commit;                         // write-back bus valid
	} phase_t;

	// register cycle kind, names follow load/update/read per port
	typedef enum logic [3:0] {
		NONE    = 4'd0,                       // no register traffic
		LDA_RDB = 4'd1,                       // A written, B read
		LDA_UPB = 4'd2,                       // both written
		RDA_UPB = 4'd3,                       // A read, B written
		LDA_IMM = 4'd4,                       // A from immediate
		UPA_RDB = 4'd5,                       // A read-modify-write with B
		UPA_IMM = 4'd6                        // A read-modify-write with imm
	} regSeq_t;

	typedef enum logic [2:0] {
		PASS_B        = 3'd0,                 // A <- B
		ADD           = 3'd1,
		SUB           = 3'd2,
		AND           = 3'd3,
		PASS_IMM      = 3'd4,                 // A <- imm
		ADD_IMM       = 3'd5,
		A_PLUS_B_TO_B = 3'd6,                 // B <- A+B
		SWAP          = 3'd7                  // A <- B, B <- A
	} aluOp_t;

	typedef struct packed {
		regSeq_t                 seq;
		aluOp_t                  op;
		logic [`REG_IDX_W-1:0]   idxA;
		logic [`REG_IDX_W-1:0]   idxB;
		logic [`IMM_W-1:0]       imm;
	} decoded_t;

	typedef struct packed {
		logic aEn;                            // port A read during EXECUTE
		logic aWen;                           // port A write during COMMIT
		logic bEn;
		logic bWen;
	} portCtl_t;

	typedef struct packed {
		logic                    aWen;
		logic [`REG_IDX_W-1:0]   aIdx;
		logic [`REG_DATA_W-1:0]  aData;
		logic                    bWen;
		logic [`REG_IDX_W-1:0]   bIdx;
		logic [`REG_DATA_W-1:0]  bData;
	} writeBack_t;

endpackage

// ==== verilog/phaseSequencer.sv ====
`timescale 1ns/1ns

// four phase timebase with one cycle per phase
module phaseSequencer (
	input  logic               CLK,
	input  logic               RESET,
	output regCorePkg::phase_t phase
);

	logic [3:0] ringQ;                        // fetch, decode, execute, commit

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			ringQ <= 4'b1000;                     // fetch first
		end else begin
			ringQ <= {ringQ[0], ringQ[3:1]};      // rotate toward commit and wrap to fetch
		end
	end

	// field order of phase_t matches the ring bits
	assign phase.fetch   = ringQ[3];
	assign phase.decode  = ringQ[2];
	assign phase.execute = ringQ[1];
	assign phase.commit  = ringQ[0];

endmodule

// ==== verilog/opxDecoder.sv ====
`timescale 1ns/1ns
`include "regCore_params.svh"

// latches the instruction word and splits it into register sequence and ALU op
module opxDecoder (
	input  logic                   CLK,
	input  logic                   RESET,
	input  regCorePkg::phase_t     phase,
	input  logic [`INSTR_W-1:0]    instr,
	output regCorePkg::decoded_t   dec
);

	localparam int OpcodeW = 4;

	localparam logic [OpcodeW-1:0] OpNop  = 4'd0;
	localparam logic [OpcodeW-1:0] OpMov  = 4'd1;
	localparam logic [OpcodeW-1:0] OpAdd  = 4'd2;
	localparam logic [OpcodeW-1:0] OpSub  = 4'd3;
	localparam logic [OpcodeW-1:0] OpAnd  = 4'd4;
	localparam logic [OpcodeW-1:0] OpLdi  = 4'd5;
	localparam logic [OpcodeW-1:0] OpAddi = 4'd6;
	localparam logic [OpcodeW-1:0] OpSwap = 4'd7;
	localparam logic [OpcodeW-1:0] OpStb  = 4'd8;
	localparam logic [OpcodeW-1:0] OpAddb = 4'd9;

	logic [`INSTR_W-1:0] instrQ;             // held from end of FETCH to next FETCH end
	logic [OpcodeW-1:0]  opcode;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			instrQ <= '0;                         // decodes as NOP
		end else if (phase.fetch) begin
			instrQ <= instr;
		end
	end

	assign opcode = instrQ[`INSTR_W-1 -: OpcodeW];

	// operand fields, imm overlaps idxB
	assign dec.idxA = instrQ[`INSTR_W-OpcodeW-1 -: `REG_IDX_W];
	assign dec.idxB = instrQ[`INSTR_W-OpcodeW-`REG_IDX_W-1 -: `REG_IDX_W];
	assign dec.imm  = instrQ[`IMM_W-1:0];

	always_comb begin
		dec.seq = regCorePkg::NONE;             // unused opcodes write nothing
		dec.op  = regCorePkg::PASS_B;
		case (opcode)
			OpNop: begin
				dec.seq = regCorePkg::NONE;
			end
			OpMov: begin
				dec.seq = regCorePkg::LDA_RDB;
				dec.op  = regCorePkg::PASS_B;
			end
			OpAdd, OpSub, OpAnd: begin
				dec.seq = regCorePkg::UPA_RDB;
				dec.op  = (opcode == OpAdd) ? regCorePkg::ADD :
				          (opcode == OpSub) ? regCorePkg::SUB : regCorePkg::AND;
			end
			OpLdi: begin
				dec.seq = regCorePkg::LDA_IMM;
				dec.op  = regCorePkg::PASS_IMM;
			end
			OpAddi: begin
				dec.seq = regCorePkg::UPA_IMM;
				dec.op  = regCorePkg::ADD_IMM;
			end
			OpSwap: begin
				dec.seq = regCorePkg::LDA_UPB;
				dec.op  = regCorePkg::SWAP;
			end
			OpStb: begin
				dec.seq = regCorePkg::RDA_UPB;      // only B written, so swap yields B <- A
				dec.op  = regCorePkg::SWAP;
			end
			OpAddb: begin
				dec.seq = regCorePkg::RDA_UPB;
				dec.op  = regCorePkg::A_PLUS_B_TO_B;
			end
			default: begin
				dec.seq = regCorePkg::NONE;         // 10..15
			end
		endcase
	end

endmodule

// ==== verilog/registerSequencer.sv ====
`timescale 1ns/1ns

// per-code port enable table, timed by the phase strobes
module registerSequencer (
	input  logic                   CLK,
	input  logic                   RESET,
	input  regCorePkg::phase_t     phase,
	input  regCorePkg::regSeq_t    seq,
	output regCorePkg::portCtl_t   ctl
);

	regCorePkg::portCtl_t seqCtl;            // table output, not yet timed

	// field order aEn, aWen, bEn, bWen
	always_comb begin
		case (seq)
			regCorePkg::NONE: begin
				seqCtl = 4'b0000;
			end
			regCorePkg::LDA_RDB: begin
				seqCtl = 4'b1110;                   // B read, A loaded
			end
			regCorePkg::LDA_UPB: begin
				seqCtl = 4'b1111;                   // both sides swap
			end
			regCorePkg::RDA_UPB: begin
				seqCtl = 4'b1011;
			end
			regCorePkg::LDA_IMM: begin
				seqCtl = 4'b1100;
			end
			regCorePkg::UPA_RDB: begin
				seqCtl = 4'b1110;
			end
			regCorePkg::UPA_IMM: begin
				seqCtl = 4'b1100;
			end
			default: begin
				seqCtl = 4'b0000;
			end
		endcase
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			ctl <= '0;
		end else begin
			ctl.aEn  <= phase.decode & seqCtl.aEn;   // high through EXECUTE
			ctl.bEn  <= phase.decode & seqCtl.bEn;
			ctl.aWen <= phase.execute & seqCtl.aWen; // high through COMMIT
			ctl.bWen <= phase.execute & seqCtl.bWen;
		end
	end

endmodule

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ns
`include "regCore_params.svh"

// 16 word array, two read/write ports
module registerFile (
	input  logic                     CLK,
	input  logic                     RESET,
	input  regCorePkg::portCtl_t     ctl,
	input  logic [`REG_IDX_W-1:0]    idxA,
	input  logic [`REG_IDX_W-1:0]    idxB,
	input  regCorePkg::writeBack_t   wb,
	output logic [`REG_DATA_W-1:0]   opA,
	output logic [`REG_DATA_W-1:0]   opB
);

	logic [`REG_DATA_W-1:0] regs [`REG_COUNT];

	// operands only driven while the port is enabled
	assign opA = ctl.aEn ? regs[idxA] : '0;
	assign opB = ctl.bEn ? regs[idxB] : '0;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wb.bWen) begin
				regs[wb.bIdx] <= wb.bData;
			end
			if (wb.aWen) begin
				regs[wb.aIdx] <= wb.aData;          // last assignment, A wins on same index
			end
		end
	end

endmodule

// ==== verilog/execUnit.sv ====
`timescale 1ns/1ns
`include "regCore_params.svh"

// forms write-back data from the latched operands
module execUnit (
	input  logic                     CLK,
	input  logic                     RESET,
	input  regCorePkg::portCtl_t     ctl,
	input  regCorePkg::decoded_t     dec,
	input  logic [`REG_DATA_W-1:0]   opA,
	input  logic [`REG_DATA_W-1:0]   opB,
	output regCorePkg::writeBack_t   wb
);

	logic [`REG_DATA_W-1:0] opAQ;            // captured at end of EXECUTE
	logic [`REG_DATA_W-1:0] opBQ;
	logic [`REG_DATA_W-1:0] immExt;
	logic [`REG_DATA_W-1:0] sumAB;

	// enables are only high during EXECUTE
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			opAQ <= '0;
			opBQ <= '0;
		end else if (ctl.aEn | ctl.bEn) begin
			opAQ <= opA;                          // zero when port A idle
			opBQ <= opB;
		end
	end

	assign immExt = {{(`REG_DATA_W-`IMM_W){1'b0}}, dec.imm};
	assign sumAB  = opAQ + opBQ;              // wraps mod 2**16

	always_comb begin
		case (dec.op)
			regCorePkg::PASS_B:   wb.aData = opBQ;
			regCorePkg::ADD:      wb.aData = sumAB;
			regCorePkg::SUB:      wb.aData = opAQ - opBQ;
			regCorePkg::AND:      wb.aData = opAQ & opBQ;
			regCorePkg::PASS_IMM: wb.aData = immExt;
			regCorePkg::ADD_IMM:  wb.aData = opAQ + immExt;
			regCorePkg::SWAP:     wb.aData = opBQ;
			default:              wb.aData = opAQ;
		endcase
	end

	// port B only ever takes A or A+B
	assign wb.bData = (dec.op == regCorePkg::A_PLUS_B_TO_B) ? sumAB : opAQ;

	// indices and strobes go straight through
	assign wb.aIdx = dec.idxA;
	assign wb.bIdx = dec.idxB;
	assign wb.aWen = ctl.aWen;
	assign wb.bWen = ctl.bWen;

endmodule

// ==== verilog/regCore.sv ====
`timescale 1ns/1ns
`include "regCore_params.svh"

// register side of the stack-machine core
module regCore (
	input  logic                     CLK,
	input  logic                     RESET,
	input  logic [`INSTR_W-1:0]      instr,
	output logic                     instrTake,
	output regCorePkg::writeBack_t   wb
);

	regCorePkg::phase_t     phase;
	regCorePkg::decoded_t   dec;
	regCorePkg::portCtl_t   ctl;
	logic [`REG_DATA_W-1:0] opA;
	logic [`REG_DATA_W-1:0] opB;

	// driver may change instr once it sees this at an edge
	assign instrTake = phase.fetch;

	phaseSequencer phaseSeq (
		.CLK   (CLK),
		.RESET (RESET),
		.phase (phase)
	);

	opxDecoder opxDec (
		.CLK   (CLK),
		.RESET (RESET),
		.phase (phase),
		.instr (instr),
		.dec   (dec)
	);

	registerSequencer regSeq (
		.CLK   (CLK),
		.RESET (RESET),
		.phase (phase),
		.seq   (dec.seq),
		.ctl   (ctl)
	);

	registerFile regFile (
		.CLK   (CLK),
		.RESET (RESET),
		.ctl   (ctl),
		.idxA  (dec.idxA),
		.idxB  (dec.idxB),
		.wb    (wb),                           // written at end of COMMIT
		.opA   (opA),
		.opB   (opB)
	);

	execUnit exec (
		.CLK   (CLK),
		.RESET (RESET),
		.ctl   (ctl),
		.dec   (dec),
		.opA   (opA),
		.opB   (opB),
		.wb    (wb)
	);

endmodule

// ==== tb/regCoreChecker.sv ====
`timescale 1ns/1ns
`include "regCore_params.svh"

// compares the write-back bus against the queued expected writes
module regCoreChecker (
	input logic                   CLK,
	input logic                   RESET,
	input logic                   instrTake,
	input regCorePkg::writeBack_t wb
);

	regCorePkg::writeBack_t expQ[$];          // oldest writing instruction first
	string                  testName = "idle";
	int                     testChecks;
	int                     testErrors;
	int                     testsRun;
	int                     totalChecks;
	int                     totalErrors;
	int                     gapCycles;            // edges since last instrTake
	bit                     takeSeen;

	// disabled ports carry no meaning, so only enabled fields count
	function automatic bit sameWrite(input regCorePkg::writeBack_t e,
			input regCorePkg::writeBack_t a);
		return (e.aWen == a.aWen) && (e.bWen == a.bWen)
			&& (!e.aWen || (e.aIdx == a.aIdx && e.aData == a.aData))
			&& (!e.bWen || (e.bIdx == a.bIdx && e.bData == a.bData));
	endfunction

	task automatic expectWrite(input regCorePkg::writeBack_t e);
		expQ.push_back(e);
	endtask

	task automatic startTest(input string name);
		testName   = name;
		testChecks = 0;
		testErrors = 0;
	endtask

	task automatic noteError();
		testErrors++;
		totalErrors++;
	endtask

	// leftovers mean the DUT skipped a write-back
	task automatic endTest();
		if (expQ.size() != 0) begin
			$display("%0d expected write-backs never appeared in test %s",
				expQ.size(), testName);
			noteError();
			expQ.delete();
		end
		$display("test %s done: %0d write-backs checked, %0d errors",
			testName, testChecks, testErrors);
		testsRun++;
	endtask

	always @(posedge CLK) begin : compareWb
		regCorePkg::writeBack_t e;
		if (!RESET && (wb.aWen || wb.bWen)) begin
			if (expQ.size() == 0) begin
				$display("write-back seen with no instruction pending in test %s", testName);
				noteError();
			end else begin
				e = expQ.pop_front();
				testChecks++;
				totalChecks++;
				if (!sameWrite(e, wb)) begin
					$display("FAILED %s: expected A%0b/%0d/%h B%0b/%0d/%h, actual A%0b/%0d/%h B%0b/%0d/%h",
						testName, e.aWen, e.aIdx, e.aData, e.bWen, e.bIdx, e.bData,
						wb.aWen, wb.aIdx, wb.aData, wb.bWen, wb.bIdx, wb.bData);
					noteError();
				end
			end
		end
	end

	// one instruction every 4 cycles
	always @(posedge CLK) begin : watchCadence
		if (RESET) begin
			gapCycles = 0;
			takeSeen  = 1'b0;
		end else begin
			gapCycles = gapCycles + 1;
			if (instrTake) begin
				if (takeSeen && gapCycles != 4) begin
					$display("instrTake came %0d cycles after the previous one instead of 4 in test %s",
						gapCycles, testName);
					noteError();
				end
				gapCycles = 0;
				takeSeen  = 1'b1;
			end
		end
	end

endmodule

// ==== tb/regCoreTb.sv ====
`timescale 1ns/1ns
`include "regCore_params.svh"

// feeds regCore with LFSR-built instruction streams
module regCoreTb;

	localparam int InstrCount     = 560 + 5 * 2 + 1;  // test bodies, drain slots, first NOP
	localparam int WatchdogCycles = InstrCount * 4 + 50;

	logic                   CLK;
	logic                   RESET;
	logic [`INSTR_W-1:0]    instr;
	logic                   instrTake;
	regCorePkg::writeBack_t wb;

	logic [`REG_DATA_W-1:0] modelRegs [`REG_COUNT];  // register state after each issued instr
	logic [`INSTR_W-1:0]    prog[$];                 // waiting to be issued
	logic [31:0]            lfsrState = 32'he59a5863;
	int                     fetchCount = 0;          // instrTake edges since reset

	regCore dut (
		.CLK       (CLK),
		.RESET     (RESET),
		.instr     (instr),
		.instrTake (instrTake),
		.wb        (wb)
	);

	regCoreChecker wbCheck (
		.CLK       (CLK),
		.RESET     (RESET),
		.instrTake (instrTake),
		.wb        (wb)
	);

	always #5 CLK = ~CLK;                           // 10 ns period

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] randBits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			r = {r[14:0], lfsrState[0]};              // one step per bit
		end
		return r;
	endfunction

	function automatic logic [`INSTR_W-1:0] makeInstr(input logic [15:0] op,
			input logic [15:0] a, input logic [15:0] low);
		return {op[3:0], a[3:0], low[7:0]};
	endfunction

	// expected write-back from the instruction table and the model state
	function automatic regCorePkg::writeBack_t expectedWriteBack(input logic [`INSTR_W-1:0] ins);
		regCorePkg::writeBack_t e;
		logic [`REG_DATA_W-1:0] va;
		logic [`REG_DATA_W-1:0] vb;
		logic [`REG_DATA_W-1:0] imm;
		e    = '0;
		e.aIdx = ins[11:8];
		e.bIdx = ins[7:4];
		va   = modelRegs[ins[11:8]];
		vb   = modelRegs[ins[7:4]];
		imm  = {8'h00, ins[7:0]};                   // zero-extended
		case (ins[15:12])
			4'd1: begin                                           // MOV
				e.aWen  = 1'b1;
				e.aData = vb;
			end
			4'd2: begin                                           // ADD
				e.aWen  = 1'b1;
				e.aData = va + vb;
			end
			4'd3: begin                                           // SUB
				e.aWen  = 1'b1;
				e.aData = va - vb;
			end
			4'd4: begin                                           // AND
				e.aWen  = 1'b1;
				e.aData = va & vb;
			end
			4'd5: begin                                           // LDI
				e.aWen  = 1'b1;
				e.aData = imm;
			end
			4'd6: begin                                           // ADDI
				e.aWen  = 1'b1;
				e.aData = va + imm;
			end
			4'd7: begin                                           // SWAP
				e.aWen = 1'b1;
				e.aData = vb;
				e.bWen = 1'b1;
				e.bData = va;
			end
			4'd8: begin                                           // STB
				e.bWen  = 1'b1;
				e.bData = va;
			end
			4'd9: begin                                           // ADDB
				e.bWen  = 1'b1;
				e.bData = va + vb;
			end
			default: e = '0;                                      // NOP and 10..15
		endcase
		return e;
	endfunction

	function automatic void applyToModel(input regCorePkg::writeBack_t e);
		if (e.bWen) begin
			modelRegs[e.bIdx] = e.bData;
		end
		if (e.aWen) begin
			modelRegs[e.aIdx] = e.aData;              // A wins on same index
		end
	endfunction

	// next instruction goes out once the DUT took the current one
	always @(posedge CLK) begin : feedInstr
		logic [`INSTR_W-1:0]    nextInstr;
		regCorePkg::writeBack_t e;
		if (!RESET && instrTake) begin
			fetchCount = fetchCount + 1;
			if (prog.size() != 0) begin
				nextInstr = prog.pop_front();
				e = expectedWriteBack(nextInstr);
				applyToModel(e);
				if (e.aWen || e.bWen) begin
					wbCheck.expectWrite(e);
				end
				instr <= nextInstr;
			end else begin
				instr <= '0;                            // idle slots run NOP
			end
		end
	end

	// last instr is latched one take later and committed before the next take
	task automatic runTest(input string name);
		int target;
		target = fetchCount + prog.size() + 2;
		wbCheck.startTest(name);
		wait (fetchCount >= target);
		@(negedge CLK);
		wbCheck.endTest();
	endtask

	initial begin
		logic [15:0] op;
		logic [15:0] a;
		logic [15:0] b;
		CLK   = 1'b0;
		RESET = 1'b1;
		instr = '0;                                 // first instruction is a NOP
		for (int i = 0; i < `REG_COUNT; i++) begin
			modelRegs[i] = '0;
		end
		repeat (8) @(posedge CLK);
		RESET <= 1'b0;
		@(negedge CLK);

		for (int i = 0; i < 20; i++) begin          // NOP and opcodes 10..15
			op = randBits(3);
			op = (op < 16'd6) ? op + 16'd10 : 16'd0;
			a  = randBits(4);
			b  = randBits(8);
			prog.push_back(makeInstr(op, a, b));
		end
		runTest("nopUnused");

		for (int i = 0; i < `REG_COUNT; i++) begin  // LDI every register
			b = randBits(8);
			prog.push_back(makeInstr(16'd5, 16'(i), b));
		end
		for (int i = 0; i < 16; i++) begin
			a = randBits(4);
			b = randBits(8);
			prog.push_back(makeInstr(16'd1, a, b));   // MOV
		end
		runTest("ldiMov");

		for (int i = 0; i < 80; i++) begin          // ADD, SUB, AND, ADDI
			op = randBits(2);
			op = (op == 16'd3) ? 16'd6 : op + 16'd2;
			a  = randBits(4);
			b  = randBits(8);
			prog.push_back(makeInstr(op, a, b));
		end
		runTest("aluRandom");

		for (int i = 0; i < 24; i++) begin          // SWAP, STB, ADDB in turn
			a = randBits(4);
			b = randBits(8);
			prog.push_back(makeInstr(16'(7 + i % 3), a, b));
		end
		for (int i = 0; i < 4; i++) begin           // SWAP with one register twice
			a = randBits(4);
			b = randBits(4);
			prog.push_back(makeInstr(16'd7, a, {8'h00, a[3:0], b[3:0]}));
		end
		runTest("swapStb");

		for (int i = 0; i < 400; i++) begin         // all 16 opcodes
			op = randBits(4);
			a  = randBits(4);
			b  = randBits(8);
			prog.push_back(makeInstr(op, a, b));
		end
		runTest("randomMix");

		$display("tests run %0d, write-backs checked %0d, errors %0d",
			wbCheck.testsRun, wbCheck.totalChecks, wbCheck.totalErrors);
		if (wbCheck.totalErrors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WatchdogCycles) @(posedge CLK);
		$display("timeout after %0d cycles, the instruction stream did not drain",
			WatchdogCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== regCore.f ====
+incdir+verilog
verilog/regCorePkg.sv
verilog/phaseSequencer.sv
verilog/opxDecoder.sv
verilog/registerSequencer.sv
verilog/registerFile.sv
verilog/execUnit.sv
verilog/regCore.sv
tb/regCoreChecker.sv
tb/regCoreTb.sv

// ==== Bender.yml ====
package:
  name: regCore

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/regCorePkg.sv
      - verilog/phaseSequencer.sv
      - verilog/opxDecoder.sv
      - verilog/registerSequencer.sv
      - verilog/registerFile.sv
      - verilog/execUnit.sv
      - verilog/regCore.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - tb/regCoreChecker.sv
      - tb/regCoreTb.sv
